// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= riscv_branch_tb
FILELIST  ?= riscv_branch_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/riscv_branch.sv ====
`timescale 1ns/1ps

module riscv_branch
(
    input  riscv_branch_pkg::branch_cond_t i_riscv_branch_cond,
    input  riscv_branch_pkg::xlen_t        i_riscv_branch_rs1data,
    input  riscv_branch_pkg::xlen_t        i_riscv_branch_rs2data,
    output logic                           o_riscv_branch_taken
);

    logic eq;                                  // operands equal
    logic lt;                                  // rs1 below rs2, signed or unsigned
    logic is_unsigned;                         // funct3[1] picks unsigned compare
    riscv_branch_pkg::branch_funct_e funct;

    assign is_unsigned = i_riscv_branch_cond[1];
    assign funct = riscv_branch_pkg::branch_funct_e'(i_riscv_branch_cond[2:0]);

    // equality is the same for both flavours
    assign eq = (i_riscv_branch_rs1data == i_riscv_branch_rs2data);

    always_comb
    begin
        if (is_unsigned)
        begin
            lt = (i_riscv_branch_rs1data < i_riscv_branch_rs2data);
        end
        else
        begin
            lt = ($signed(i_riscv_branch_rs1data) < $signed(i_riscv_branch_rs2data));
        end
    end

    always_comb
    begin
        o_riscv_branch_taken = 1'b0;                       // default not taken
        if (i_riscv_branch_cond[3])                        // only real branches
        begin
            case (funct)
                riscv_branch_pkg::BEQ:  o_riscv_branch_taken = eq;
                riscv_branch_pkg::BNE:  o_riscv_branch_taken = ~eq;
                riscv_branch_pkg::BLT:  o_riscv_branch_taken = lt;
                riscv_branch_pkg::BGE:  o_riscv_branch_taken = ~lt;   // ge is not lt
                riscv_branch_pkg::BLTU: o_riscv_branch_taken = lt;
                riscv_branch_pkg::BGEU: o_riscv_branch_taken = ~lt;
                default:                o_riscv_branch_taken = 1'b0;  // reserved 2, 3
            endcase
        end
    end

endmodule

// ==== design/riscv_branch_cfg.svh ====
`ifndef RISCV_BRANCH_CFG_SVH
`define RISCV_BRANCH_CFG_SVH

// operand and pc width
`define RISCV_XLEN 64

// resolution lanes, power of two
// pointers wrap by plain increment
`define RISCV_BRANCH_LANES 4

// operation tag width
`define RISCV_BRANCH_TAG_W 6

// fixed pc step for a not-taken branch
`define RISCV_BRANCH_PC_STEP 4

`endif

// ==== design/riscv_branch_collect.sv ====
`timescale 1ns/1ps

`include "riscv_branch_cfg.svh"

module riscv_branch_collect
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic [`RISCV_BRANCH_LANES-1:0]      i_lane_full,
    input  riscv_branch_pkg::branch_res_t       i_lane_res [`RISCV_BRANCH_LANES],
    output logic [`RISCV_BRANCH_LANES-1:0]      o_lane_drain,   // one-hot
    output logic                                o_req,
    output riscv_branch_pkg::branch_res_t       o_res,
    input  logic                                i_ack
);

    riscv_branch_pkg::coll_state_e state;
    riscv_branch_pkg::coll_state_e state_nxt;
    riscv_branch_pkg::lane_idx_t   rd_ptr;
    logic                          start;    // begin a transfer
    logic                          drain;    // sink took the result
    logic                          advance;  // handshake closed

    assign start   = (state == riscv_branch_pkg::COLL_IDLE) && i_lane_full[rd_ptr] && !i_ack;
    assign drain   = (state == riscv_branch_pkg::COLL_REQ) && i_ack;
    assign advance = (state == riscv_branch_pkg::COLL_WAIT_LOW) && !i_ack;

    always_comb
    begin
        o_lane_drain = '0;
        if (drain)
        begin
            o_lane_drain[rd_ptr] = 1'b1;
        end
    end

    assign o_req = (state == riscv_branch_pkg::COLL_REQ);

    always_comb
    begin
        state_nxt = state;
        case (state)
            riscv_branch_pkg::COLL_IDLE:
            begin
                if (start)
                    state_nxt = riscv_branch_pkg::COLL_REQ;
            end
            riscv_branch_pkg::COLL_REQ:
            begin
                if (drain)
                    state_nxt = riscv_branch_pkg::COLL_WAIT_LOW;   // req falls next cycle
            end
            riscv_branch_pkg::COLL_WAIT_LOW:
            begin
                if (advance)
                    state_nxt = riscv_branch_pkg::COLL_IDLE;
            end
            default: state_nxt = riscv_branch_pkg::COLL_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state  <= riscv_branch_pkg::COLL_IDLE;
            rd_ptr <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (advance)
                rd_ptr <= rd_ptr + 1'b1;   // next lane in arrival order
        end
    end

    // result held steady through the whole req phase
    always_ff @(posedge i_clk)
    begin
        if (start)
            o_res <= i_lane_res[rd_ptr];
    end

endmodule

// ==== design/riscv_branch_dispatch.sv ====
`timescale 1ns/1ps

`include "riscv_branch_cfg.svh"

module riscv_branch_dispatch
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_req,
    input  riscv_branch_pkg::branch_op_t        i_op,
    output logic                                o_ack,
    input  logic [`RISCV_BRANCH_LANES-1:0]      i_lane_full,
    output logic [`RISCV_BRANCH_LANES-1:0]      o_lane_load,   // one-hot
    output riscv_branch_pkg::branch_op_t        o_op          // shared lane bus
);

    riscv_branch_pkg::disp_state_e state;
    riscv_branch_pkg::disp_state_e state_nxt;
    riscv_branch_pkg::lane_idx_t   wr_ptr;
    logic                          load;

    // capture when idle, request up, target lane free
    assign load = (state == riscv_branch_pkg::DISP_IDLE) && i_req && !i_lane_full[wr_ptr];

    always_comb
    begin
        o_lane_load = '0;
        if (load)
        begin
            o_lane_load[wr_ptr] = 1'b1;
        end
    end

    assign o_op  = i_op;                                  // stable while i_req is high
    assign o_ack = (state == riscv_branch_pkg::DISP_ACK); // straight off the state flop

    always_comb
    begin
        state_nxt = state;
        case (state)
            riscv_branch_pkg::DISP_IDLE:
            begin
                if (load)
                begin
                    state_nxt = riscv_branch_pkg::DISP_ACK;
                end
            end
            riscv_branch_pkg::DISP_ACK:
            begin
                if (!i_req)                               // source done, drop ack
                begin
                    state_nxt = riscv_branch_pkg::DISP_IDLE;
                end
            end
            default: state_nxt = riscv_branch_pkg::DISP_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state  <= riscv_branch_pkg::DISP_IDLE;
            wr_ptr <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (load)
            begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, lane count is a power of two
            end
        end
    end

endmodule

// ==== design/riscv_branch_lane.sv ====
`timescale 1ns/1ps

`include "riscv_branch_cfg.svh"

module riscv_branch_lane
(
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_load,     // from dispatcher, one cycle
    input  logic                          i_drain,    // from collector, one cycle
    input  riscv_branch_pkg::branch_op_t  i_op,
    output logic                          o_full,
    output riscv_branch_pkg::branch_res_t o_res
);

    logic                    taken;
    riscv_branch_pkg::xlen_t target;     // pc + imm
    riscv_branch_pkg::xlen_t fall_thru;  // pc + 4
    riscv_branch_pkg::xlen_t next_pc;

    riscv_branch u_cmp
    (
        .i_riscv_branch_cond    (i_op.cond),
        .i_riscv_branch_rs1data (i_op.rs1),
        .i_riscv_branch_rs2data (i_op.rs2),
        .o_riscv_branch_taken   (taken)
    );

    assign target    = i_op.pc + i_op.imm;
    assign fall_thru = i_op.pc + riscv_branch_pkg::xlen_t'(`RISCV_BRANCH_PC_STEP);
    assign next_pc   = taken ? target : fall_thru;

    // occupancy flag
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_full <= 1'b0;
        end
        else if (i_load)
        begin
            o_full <= 1'b1;      // load wins, never both on one lane
        end
        else if (i_drain)
        begin
            o_full <= 1'b0;
        end
    end

    // resolved result, held until drained
    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            o_res.taken      <= taken;
            o_res.mispredict <= taken ^ i_op.predicted;
            o_res.next_pc    <= next_pc;
            o_res.tag        <= i_op.tag;
        end
    end

endmodule

// ==== design/riscv_branch_pkg.sv ====
`include "riscv_branch_cfg.svh"

package riscv_branch_pkg;

    typedef logic [`RISCV_XLEN-1:0] xlen_t;                        // data word or pc
    typedef logic [3:0] branch_cond_t;                             // [3] branch, [2:0] funct3
    typedef logic [`RISCV_BRANCH_TAG_W-1:0] branch_tag_t;
    typedef logic [$clog2(`RISCV_BRANCH_LANES)-1:0] lane_idx_t;    // lane pointer

    // funct3 of the conditional branches, 2 and 3 reserved
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } branch_funct_e;

    typedef struct packed {
        branch_cond_t cond;
        xlen_t        rs1;
        xlen_t        rs2;
        xlen_t        pc;
        xlen_t        imm;         // already sign-extended
        logic         predicted;   // front end guess
        branch_tag_t  tag;
    } branch_op_t;

    typedef struct packed {
        logic         taken;
        logic         mispredict;
        xlen_t        next_pc;
        branch_tag_t  tag;
    } branch_res_t;

    typedef enum logic [1:0] {DISP_IDLE, DISP_ACK} disp_state_e;
    typedef enum logic [1:0] {COLL_IDLE, COLL_REQ, COLL_WAIT_LOW} coll_state_e;

endpackage

// ==== design/riscv_branch_unit.sv ====
`timescale 1ns/1ps

`include "riscv_branch_cfg.svh"

module riscv_branch_unit
(
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_req,    // input channel
    input  riscv_branch_pkg::branch_op_t  i_op,
    output logic                          o_ack,
    output logic                          o_req,    // output channel
    output riscv_branch_pkg::branch_res_t o_res,
    input  logic                          i_ack
);

    logic [`RISCV_BRANCH_LANES-1:0] lane_load;
    logic [`RISCV_BRANCH_LANES-1:0] lane_drain;
    logic [`RISCV_BRANCH_LANES-1:0] lane_full;
    riscv_branch_pkg::branch_op_t   lane_op;                          // broadcast to all lanes
    riscv_branch_pkg::branch_res_t  lane_res [`RISCV_BRANCH_LANES];

    riscv_branch_dispatch u_dispatch
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_op        (i_op),
        .o_ack       (o_ack),
        .i_lane_full (lane_full),
        .o_lane_load (lane_load),
        .o_op        (lane_op)
    );

    // identical lanes, filled and drained round robin
    for (genvar g = 0; g < `RISCV_BRANCH_LANES; g++)
    begin : g_lane
        riscv_branch_lane u_lane
        (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_load  (lane_load[g]),
            .i_drain (lane_drain[g]),
            .i_op    (lane_op),
            .o_full  (lane_full[g]),
            .o_res   (lane_res[g])
        );
    end

    riscv_branch_collect u_collect
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_lane_full  (lane_full),
        .i_lane_res   (lane_res),
        .o_lane_drain (lane_drain),
        .o_req        (o_req),
        .o_res        (o_res),
        .i_ack        (i_ack)
    );

endmodule

// ==== riscv_branch_unit.f ====
+incdir+design
design/riscv_branch_pkg.sv
design/riscv_branch.sv
design/riscv_branch_lane.sv
design/riscv_branch_dispatch.sv
design/riscv_branch_collect.sv
design/riscv_branch_unit.sv
verif/riscv_branch_clkgen.sv
verif/riscv_branch_monitor.sv
verif/riscv_branch_checker.sv
verif/riscv_branch_tb.sv

// ==== verif/riscv_branch_checker.sv ====
`timescale 1ns/1ps

module riscv_branch_checker
(
    input logic                          i_clk,
    input logic                          i_reset,
    input logic                          i_in_req,
    input logic                          i_in_ack,
    input logic                          i_out_req,
    input logic                          i_out_ack,
    input riscv_branch_pkg::branch_res_t i_out_res
);

    int fail_count = 0;

    // ack only answers a pending request
    ack_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_in_ack) |-> i_in_req)
        else
        begin
            fail_count++;
            $error("o_ack rose while i_req was low");
        end

    req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_out_req && !i_out_ack) |=> i_out_req)   // no withdrawn offers
        else
        begin
            fail_count++;
            $error("o_req dropped before i_ack rose");
        end

    res_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_out_req |=> (!i_out_req || $stable(i_out_res)))
        else
        begin
            fail_count++;
            $error("o_res changed while o_req was high");
        end

    // both channels quiet right out of reset
    reset_idle: assert property (@(posedge i_clk)
        $past(i_reset) |-> (!i_in_ack && !i_out_req))
        else
        begin
            fail_count++;
            $error("o_ack or o_req high in the cycle after reset");
        end

endmodule

bind riscv_branch_unit riscv_branch_checker u_checker
(
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_in_req  (i_req),
    .i_in_ack  (o_ack),
    .i_out_req (o_req),
    .i_out_ack (i_ack),
    .i_out_res (o_res)
);

// ==== verif/riscv_branch_clkgen.sv ====
`timescale 1ns/1ps

module riscv_branch_clkgen
(
    output logic o_clk,
    output logic o_reset
);

    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;      // 4 ns period
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (5) @(posedge o_clk);    // five cycles in reset
        #1 o_reset = 1'b0;
    end

endmodule

// ==== verif/riscv_branch_monitor.sv ====
`timescale 1ns/1ps

module riscv_branch_monitor
(
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  riscv_branch_pkg::branch_op_t  i_op,        // input channel
    input  logic                          i_op_ack,
    input  riscv_branch_pkg::branch_res_t i_res,       // output channel
    input  logic                          i_res_req,
    output int                            o_in_count,
    output int                            o_out_count,
    output int                            o_error_count
);

    riscv_branch_pkg::branch_res_t expect_q [$];       // results in arrival order
    riscv_branch_pkg::branch_res_t exp_res;
    logic                          ack_q;
    logic                          req_q;

    // taken straight from the branch rules
    function automatic logic model_taken(input riscv_branch_pkg::branch_op_t op);
        logic t;
        t = 1'b0;
        if (op.cond[3])
        begin
            case (op.cond[2:0])
                3'd0:    t = (op.rs1 == op.rs2);
                3'd1:    t = (op.rs1 != op.rs2);
                3'd4:    t = ($signed(op.rs1) < $signed(op.rs2));
                3'd5:    t = ($signed(op.rs1) >= $signed(op.rs2));
                3'd6:    t = (op.rs1 < op.rs2);
                3'd7:    t = (op.rs1 >= op.rs2);
                default: t = 1'b0;                   // 2 and 3 reserved
            endcase
        end
        return t;
    endfunction

    function automatic riscv_branch_pkg::branch_res_t model_result(
        input riscv_branch_pkg::branch_op_t op);
        riscv_branch_pkg::branch_res_t r;
        r.taken      = model_taken(op);
        r.mispredict = (r.taken != op.predicted);
        r.next_pc    = r.taken ? op.pc + op.imm : op.pc + 64'd4;
        r.tag        = op.tag;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("Error %s expected %h actual %h", name, exp_v, act_v);
            o_error_count++;
        end
    endtask

    always @(posedge i_clk)
    begin
        if (i_reset)
        begin
            ack_q         <= 1'b0;
            req_q         <= 1'b0;
            o_in_count    = 0;
            o_out_count   = 0;
            o_error_count = 0;
        end
        else
        begin
            ack_q <= i_op_ack;
            req_q <= i_res_req;
            if (i_op_ack && !ack_q)                  // op captured, i_op still valid
            begin
                expect_q.push_back(model_result(i_op));
                o_in_count++;
            end
            if (i_res_req && !req_q)                 // new result offered
            begin
                o_out_count++;
                if (expect_q.size() == 0)
                begin
                    $display("result with tag %h came out with no operation pending",
                             i_res.tag);
                    o_error_count++;
                end
                else
                begin
                    exp_res = expect_q.pop_front();
                    check_field("taken", 64'(exp_res.taken), 64'(i_res.taken));
                    check_field("mispredict", 64'(exp_res.mispredict), 64'(i_res.mispredict));
                    check_field("next_pc", exp_res.next_pc, i_res.next_pc);
                    check_field("tag", 64'(exp_res.tag), 64'(i_res.tag));  // order check
                end
            end
        end
    end

endmodule

// ==== verif/riscv_branch_tb.sv ====
`timescale 1ns/1ps

module riscv_branch_tb;

    localparam int NUM_TESTS      = 4;
    localparam int OPS_PER_TEST   = 300;
    localparam int CYCLES_PER_OP  = 40;       // covers the slow sink too
    localparam int TIMEOUT_CYCLES = NUM_TESTS * OPS_PER_TEST * CYCLES_PER_OP;

    logic                          clk;
    logic                          reset;
    logic                          op_req;
    riscv_branch_pkg::branch_op_t  op;
    logic                          op_ack;
    logic                          res_req;
    riscv_branch_pkg::branch_res_t res;
    logic                          res_ack;
    int                            in_count;
    int                            out_count;
    int                            error_count;
    integer                        seed = 32'h26c57e47;
    integer                        sink_seed;
    int                            sink_max = 3;   // longest ack delay in cycles
    int                            cycles = 0;
    int                            sent = 0;

    riscv_branch_clkgen u_clkgen (.o_clk(clk), .o_reset(reset));

    riscv_branch_unit dut0
    (
        .i_clk   (clk),
        .i_reset (reset),
        .i_req   (op_req),
        .i_op    (op),
        .o_ack   (op_ack),
        .o_req   (res_req),
        .o_res   (res),
        .i_ack   (res_ack)
    );

    riscv_branch_monitor u_monitor
    (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_op          (op),
        .i_op_ack      (op_ack),
        .i_res         (res),
        .i_res_req     (res_req),
        .o_in_count    (in_count),
        .o_out_count   (out_count),
        .o_error_count (error_count)
    );

    // sign-bit extremes for the ordered compares
    function automatic riscv_branch_pkg::xlen_t edge_value(input logic [2:0] sel,
                                                          input riscv_branch_pkg::xlen_t rnd);
        case (sel)
            3'd0:    return 64'h8000_0000_0000_0000;    // most negative
            3'd1:    return 64'h7fff_ffff_ffff_ffff;
            3'd2:    return '1;                         // all ones
            3'd3:    return '0;
            3'd4:    return 64'd1;
            3'd5:    return {1'b1, rnd[62:0]};          // some negative
            default: return rnd;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "beq_bne";
            2:       return "ordered_compares";
            3:       return "never_taken";
            default: return "slow_sink_order";
        endcase
    endfunction

    task automatic build_op(input int test_id, input int idx,
                            output riscv_branch_pkg::branch_op_t o);
        logic [31:0] r_a;
        logic [31:0] r_b;
        logic [31:0] r_c;
        logic [31:0] r_d;
        logic [31:0] r_e;
        r_a = $random(seed);
        r_b = $random(seed);
        r_c = $random(seed);
        r_d = $random(seed);
        r_e = $random(seed);
        o.rs1       = {r_a, r_b};
        o.rs2       = {r_c, r_d};
        o.pc        = {r_b ^ r_c, r_d[31:2], 2'b00};
        o.imm       = {{51{r_e[12]}}, r_e[12:1], 1'b0};   // 13 bit branch offset
        o.predicted = r_e[20];
        o.tag       = riscv_branch_pkg::branch_tag_t'(idx);
        case (test_id)
            1:
            begin
                o.cond = {3'b100, r_e[16]};
                if (r_e[17])
                    o.rs2 = o.rs1;                          // half equal
            end
            2:
            begin
                o.cond = {2'b11, r_e[17:16]};
                o.rs1  = edge_value(r_e[26:24], o.rs1);
                o.rs2  = r_e[27] ? o.rs1 : edge_value(r_e[30:28], o.rs2);
            end
            3:
            begin
                if (r_e[16])
                    o.cond = {1'b0, r_e[19:17]};            // not a branch
                else
                    o.cond = {3'b101, r_e[17]};             // funct3 2 or 3
            end
            default:
            begin
                o.cond = r_e[19:16];
                if (r_e[21])
                    o.rs2 = o.rs1;
            end
        endcase
    endtask

    // four-phase source entering and leaving on a rising edge
    task automatic send_op(input riscv_branch_pkg::branch_op_t o);
        #1;
        op     = o;
        op_req = 1'b1;
        @(posedge clk);
        while (!op_ack)
            @(posedge clk);
        #1 op_req = 1'b0;
        @(posedge clk);
        while (op_ack)
            @(posedge clk);
    endtask

    // sink with a random delay before each ack
    initial
    begin
        logic [31:0] r;
        int          delay;
        res_ack = 1'b0;
        forever
        begin
            @(posedge clk);
            if (res_req && !reset)
            begin
                r     = $random(sink_seed);
                delay = int'(r[15:0]) % (sink_max + 1);
                repeat (delay) @(posedge clk);
                #1 res_ack = 1'b1;
                @(posedge clk);
                while (res_req)
                    @(posedge clk);
                #1 res_ack = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d ops sent but only %0d results seen",
                     cycles, sent, out_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        riscv_branch_pkg::branch_op_t next_op;
        logic [31:0]                  r;
        int                           errs_before;
        int                           checker_fails;
        op_req    = 1'b0;
        op        = '0;
        sink_seed = $random(seed);
        @(posedge clk);
        while (reset)
            @(posedge clk);
        for (int t = 1; t <= NUM_TESTS; t++)
        begin
            errs_before = error_count;
            sink_max    = (t == NUM_TESTS) ? 24 : 3;       // last test starves the sink
            for (int n = 0; n < OPS_PER_TEST; n++)
            begin
                build_op(t, sent, next_op);
                send_op(next_op);
                sent++;
                r = $random(seed);
                if (t != NUM_TESTS)
                    repeat (int'(r[1:0])) @(posedge clk);  // fast source in the last test
            end
            while (out_count != sent)
                @(posedge clk);
            $display("test %0d %s: %0d ops, %0d errors", t, test_name(t), OPS_PER_TEST,
                     error_count - errs_before);
        end
        // last output handshake closes before the counts are read
        while (res_req || res_ack)
            @(posedge clk);
        checker_fails = dut0.u_checker.fail_count;
        $display("summary %0d tests, %0d sent, %0d in, %0d out, %0d errors, %0d assert fails",
                 NUM_TESTS, sent, in_count, out_count, error_count, checker_fails);
        if (error_count == 0 && checker_fails == 0 && in_count == sent && out_count == sent)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
